//--- hdl/rv_alu.sv
module rv_alu (
  input  rv_core_pkg::word_t   a,
  input  rv_core_pkg::word_t   b,
  input  rv_core_pkg::alu_op_t op,
  output rv_core_pkg::word_t   result
);

  rv_core_pkg::shamt_t shamt;

  // shifts use only the low bits of b
  assign shamt = b[$bits(rv_core_pkg::shamt_t)-1:0];

  always_comb begin
    case (op)
      rv_core_pkg::ALU_ADD: begin
        result = a + b;
      end
      rv_core_pkg::ALU_SUB: begin
        result = a - b;
      end
      rv_core_pkg::ALU_SLL: begin
        result = a << shamt;
      end
      rv_core_pkg::ALU_SLT: begin
        result = {31'b0, $signed(a) < $signed(b)};
      end
      rv_core_pkg::ALU_SLTU: begin
        result = {31'b0, a < b};
      end
      rv_core_pkg::ALU_XOR: begin
        result = a ^ b;
      end
      rv_core_pkg::ALU_SRL: begin
        result = a >> shamt;
      end
      rv_core_pkg::ALU_SRA: begin
        result = $signed(a) >>> shamt;
      end
      rv_core_pkg::ALU_OR: begin
        result = a | b;
      end
      rv_core_pkg::ALU_AND: begin
        result = a & b;
      end
      rv_core_pkg::ALU_PASS_B: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- hdl/rv_core.sv
module rv_core (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   insn_valid,
  input  rv_core_pkg::word_t     insn,
  output logic                   halt,
  output logic                   retire_valid,
  output logic                   wb_we,
  output rv_core_pkg::word_t     retire_pc,
  output rv_core_pkg::word_t     retire_insn,
  output rv_core_pkg::word_t     wb_data,
  output rv_core_pkg::reg_addr_t wb_rd
);

  logic buf_valid;
  rv_core_pkg::word_t buf_pc;
  rv_core_pkg::word_t buf_insn;

  rv_core_pkg::reg_addr_t rs1;
  rv_core_pkg::reg_addr_t rs2;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::word_t imm;
  rv_core_pkg::alu_op_t alu_op;
  logic use_imm;
  logic use_pc;
  logic rd_we;
  logic mem_read;
  logic is_ecall;
  logic load_unsigned;
  logic store_en;
  logic [1:0] mem_size;
  rv_core_pkg::wb_sel_t wb_sel;

  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  rv_core_pkg::word_t alu_a;
  rv_core_pkg::word_t alu_b;
  rv_core_pkg::word_t alu_result;
  rv_core_pkg::word_t load_data;

  rv_fetch u_fetch (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .ecall_retire (buf_valid && is_ecall),
    .buf_valid    (buf_valid),
    .buf_pc       (buf_pc),
    .buf_insn     (buf_insn),
    .halt         (halt)
  );

  rv_decode u_decode (
    .buf_insn      (buf_insn),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .imm           (imm),
    .alu_op        (alu_op),
    .use_imm       (use_imm),
    .use_pc        (use_pc),
    .rd_we         (rd_we),
    .mem_read      (mem_read),
    .is_ecall      (is_ecall),
    .load_unsigned (load_unsigned),
    .store_en      (store_en),
    .mem_size      (mem_size),
    .wb_sel        (wb_sel)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (wb_we),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // pc feeds auipc, the immediate feeds everything but reg-reg
  assign alu_a = use_pc ? buf_pc : rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  rv_dmem u_dmem (
    .clk           (clk),
    .rst           (rst),
    .addr          (alu_result),
    .store_en      (buf_valid && store_en),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .store_data    (rs2_data),
    .load_data     (load_data)
  );

  // load data only when a supported load was decoded
  assign wb_data = (wb_sel == rv_core_pkg::WB_LOAD && mem_read) ? load_data : alu_result;
  assign wb_we = buf_valid && rd_we;
  assign wb_rd = rd;

  // retire trace straight from the decode buffer
  assign retire_valid = buf_valid;
  assign retire_pc = buf_pc;
  assign retire_insn = buf_insn;

endmodule

//--- hdl/rv_core_pkg.sv
`include "rv_defines.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
  // one bit per byte lane of a word
  typedef logic [`RV_XLEN/8-1:0] byte_en_t;
  typedef logic [$clog2(`RV_XLEN)-1:0] shamt_t;

  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_SLL = 4'd2;
  localparam alu_op_t ALU_SLT = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR = 4'd5;
  localparam alu_op_t ALU_SRL = 4'd6;
  localparam alu_op_t ALU_SRA = 4'd7;
  localparam alu_op_t ALU_OR = 4'd8;
  localparam alu_op_t ALU_AND = 4'd9;
  // lui result is the immediate itself
  localparam alu_op_t ALU_PASS_B = 4'd10;

  typedef logic [1:0] wb_sel_t;

  localparam wb_sel_t WB_ALU = 2'd0;
  localparam wb_sel_t WB_LOAD = 2'd1;

endpackage

//--- hdl/rv_decode.sv
module rv_decode (
  input  rv_core_pkg::word_t     buf_insn,
  output rv_core_pkg::reg_addr_t rs1,
  output rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::reg_addr_t rd,
  output rv_core_pkg::word_t     imm,
  output rv_core_pkg::alu_op_t   alu_op,
  output logic                   use_imm,
  output logic                   use_pc,
  output logic                   rd_we,
  output logic                   mem_read,
  output logic                   is_ecall,
  output logic                   load_unsigned,
  output logic                   store_en,
  output logic [1:0]             mem_size,
  output rv_core_pkg::wb_sel_t   wb_sel
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_u;
  logic alt;

  assign opcode = buf_insn[6:0];
  assign rd = buf_insn[11:7];
  assign funct3 = buf_insn[14:12];
  assign rs1 = buf_insn[19:15];
  assign rs2 = buf_insn[24:20];
  assign funct7 = buf_insn[31:25];
  assign alt = (funct7 == rv_isa_pkg::FUNCT7_ALT);

  assign imm_i = {{20{buf_insn[31]}}, buf_insn[31:20]};
  assign imm_s = {{20{buf_insn[31]}}, buf_insn[31:25], buf_insn[11:7]};
  assign imm_u = {buf_insn[31:12], 12'b0};

  // width in funct3[1:0], zero extension in funct3[2]
  assign mem_size = funct3[1:0];
  assign load_unsigned = funct3[2];

  always_comb begin
    imm = imm_i;
    alu_op = rv_core_pkg::ALU_ADD;
    use_imm = 1'b0;
    use_pc = 1'b0;
    rd_we = 1'b0;
    mem_read = 1'b0;
    is_ecall = 1'b0;
    store_en = 1'b0;
    wb_sel = rv_core_pkg::WB_ALU;
    case (opcode)
      rv_isa_pkg::OPC_REG_IMM, rv_isa_pkg::OPC_REG_REG: begin
        use_imm = (opcode == rv_isa_pkg::OPC_REG_IMM);
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: begin
            alu_op = (alt && !use_imm) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
          end
          rv_isa_pkg::F3_SLL: alu_op = rv_core_pkg::ALU_SLL;
          rv_isa_pkg::F3_SLT: alu_op = rv_core_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR: alu_op = rv_core_pkg::ALU_XOR;
          rv_isa_pkg::F3_SRL_SRA: begin
            alu_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
          end
          rv_isa_pkg::F3_OR: alu_op = rv_core_pkg::ALU_OR;
          default: alu_op = rv_core_pkg::ALU_AND;
        endcase
        // immediate forms check funct7 only on shifts
        if (use_imm && funct3 != rv_isa_pkg::F3_SLL && funct3 != rv_isa_pkg::F3_SRL_SRA) begin
          rd_we = 1'b1;
        end else begin
          rd_we = (funct7 == rv_isa_pkg::FUNCT7_BASE)
                  || (alt && funct3 == rv_isa_pkg::F3_SRL_SRA)
                  || (alt && !use_imm && funct3 == rv_isa_pkg::F3_ADD_SUB);
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        imm = imm_u;
        use_imm = 1'b1;
        alu_op = rv_core_pkg::ALU_PASS_B;
        rd_we = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        imm = imm_u;
        use_imm = 1'b1;
        use_pc = 1'b1;
        rd_we = 1'b1;
      end
      rv_isa_pkg::OPC_LOAD: begin
        use_imm = 1'b1;
        wb_sel = rv_core_pkg::WB_LOAD;
        case (funct3)
          rv_isa_pkg::F3_BYTE, rv_isa_pkg::F3_HALF, rv_isa_pkg::F3_WORD,
          rv_isa_pkg::F3_BYTE_U, rv_isa_pkg::F3_HALF_U: begin
            mem_read = 1'b1;
            rd_we = 1'b1;
          end
          default: mem_read = 1'b0;
        endcase
      end
      rv_isa_pkg::OPC_STORE: begin
        imm = imm_s;
        use_imm = 1'b1;
        store_en = (funct3 == rv_isa_pkg::F3_BYTE) || (funct3 == rv_isa_pkg::F3_HALF)
                   || (funct3 == rv_isa_pkg::F3_WORD);
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        // only the all-zero form is ecall
        is_ecall = (buf_insn[31:7] == 25'd0);
      end
      default: rd_we = 1'b0;
    endcase
  end

endmodule

//--- hdl/rv_dmem.sv
`include "rv_defines.svh"

module rv_dmem (
  input  logic               clk,
  input  logic               rst,
  input  rv_core_pkg::word_t addr,
  input  logic               store_en,
  input  logic [1:0]         mem_size,
  input  logic               load_unsigned,
  input  rv_core_pkg::word_t store_data,
  output rv_core_pkg::word_t load_data
);

  localparam int IdxW = $clog2(`RV_DMEM_WORDS);

  rv_core_pkg::word_t mem [`RV_DMEM_WORDS];
  logic [IdxW-1:0] idx;
  rv_core_pkg::word_t rd_word;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;
  rv_core_pkg::byte_en_t byte_en;
  rv_core_pkg::word_t wr_word;

  // word index above the byte offset, upper address bits wrap
  assign idx = addr[IdxW+1:2];
  assign rd_word = mem[idx];

  always_comb begin
    case (addr[1:0])
      2'b00: ld_byte = rd_word[7:0];
      2'b01: ld_byte = rd_word[15:8];
      2'b10: ld_byte = rd_word[23:16];
      default: ld_byte = rd_word[31:24];
    endcase
    ld_half = addr[1] ? rd_word[31:16] : rd_word[15:0];
    case (mem_size)
      2'b00: load_data = {{24{ld_byte[7] && !load_unsigned}}, ld_byte};
      2'b01: load_data = {{16{ld_half[15] && !load_unsigned}}, ld_half};
      default: load_data = rd_word;
    endcase
  end

  // data replicated to every lane, the mask picks the addressed one
  always_comb begin
    case (mem_size)
      2'b00: begin
        byte_en = 4'b0001 << addr[1:0];
        wr_word = {4{store_data[7:0]}};
      end
      2'b01: begin
        byte_en = addr[1] ? 4'b1100 : 4'b0011;
        wr_word = {2{store_data[15:0]}};
      end
      default: begin
        byte_en = 4'b1111;
        wr_word = store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `RV_DMEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (store_en) begin
      for (int b = 0; b < $bits(rv_core_pkg::byte_en_t); b++) begin
        if (byte_en[b]) begin
          mem[idx][8*b +: 8] <= wr_word[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- hdl/rv_fetch.sv
`include "rv_defines.svh"

module rv_fetch (
  input  logic               clk,
  input  logic               rst,
  input  logic               insn_valid,
  input  rv_core_pkg::word_t insn,
  input  logic               ecall_retire,
  output logic               buf_valid,
  output rv_core_pkg::word_t buf_pc,
  output rv_core_pkg::word_t buf_insn,
  output logic               halt
);

  rv_core_pkg::word_t pc;
  logic accept;

  // an ecall leaving execute closes the stream, so it is the last retire
  assign accept = insn_valid && !halt && !ecall_retire;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
      buf_valid <= 1'b0;
      halt <= 1'b0;
    end else begin
      buf_valid <= accept;
      if (accept) begin
        pc <= pc + `RV_PC_STEP;
      end
      // sticky until reset
      if (ecall_retire) begin
        halt <= 1'b1;
      end
    end
  end

  // decode buffer payload
  always_ff @(posedge clk) begin
    if (accept) begin
      buf_pc <= pc;
      buf_insn <= insn;
    end
  end

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes of the supported subset
  localparam opcode_t OPC_LOAD = 7'b00_000_11;
  localparam opcode_t OPC_STORE = 7'b01_000_11;
  localparam opcode_t OPC_REG_IMM = 7'b00_100_11;
  localparam opcode_t OPC_REG_REG = 7'b01_100_11;
  localparam opcode_t OPC_LUI = 7'b01_101_11;
  localparam opcode_t OPC_AUIPC = 7'b00_101_11;
  localparam opcode_t OPC_SYSTEM = 7'b11_100_11;

  // alu funct3, shared by the immediate and register forms
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL = 3'b001;
  localparam funct3_t F3_SLT = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR = 3'b110;
  localparam funct3_t F3_AND = 3'b111;

  // load and store access width
  localparam funct3_t F3_BYTE = 3'b000;
  localparam funct3_t F3_HALF = 3'b001;
  localparam funct3_t F3_WORD = 3'b010;
  localparam funct3_t F3_BYTE_U = 3'b100;
  localparam funct3_t F3_HALF_U = 3'b101;

  localparam funct7_t FUNCT7_BASE = 7'b0000000;
  // sub and arithmetic right shifts
  localparam funct7_t FUNCT7_ALT = 7'b0100000;

endpackage

//--- hdl/rv_regfile.sv
`include "rv_defines.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_core_pkg::reg_addr_t rs1,
  input  rv_core_pkg::reg_addr_t rs2,
  input  rv_core_pkg::reg_addr_t rd,
  input  logic                   we,
  input  rv_core_pkg::word_t     rd_data,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data
);

  rv_core_pkg::word_t regs [`RV_NUM_REGS];

  // x0 is cleared by reset and never written, so it reads zero
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// data memory depth in words, addresses wrap every 256 bytes
`define RV_DMEM_WORDS 64

// pc update
`define RV_PC_STEP 4
`define RV_RESET_PC 0

`endif

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module tb_rv_core -f sim.f -o tb_rv_core \
  && ./obj_dir/tb_rv_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation exited with an error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "failure reported in sim.log"; exit 1; } || exit 0

//--- sim.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_dmem.sv
hdl/rv_core.sv
verif/rv_core_asserts.sv
verif/tb_rv_core.sv

//--- verif/rv_core_asserts.sv
module rv_core_asserts (
  input logic clk,
  input logic rst,
  input logic halt,
  input logic retire_valid,
  input logic wb_we
);

  // nothing left in the decode buffer after reset
  a_reset_quiet: assert property (@(posedge clk) rst |=> !retire_valid)
    else $error("retire_valid high in the cycle after reset");

  // halt is sticky until reset
  a_halt_sticky: assert property (@(posedge clk) $fell(halt) |-> $past(rst))
    else $error("halt fell without reset");

  // strobes are refused once halted
  a_no_retire_halted: assert property (
    @(posedge clk) disable iff (rst) $rose(retire_valid) |-> !$past(halt))
    else $error("retire_valid rose while halt was high");

  a_we_retire: assert property (@(posedge clk) wb_we |-> retire_valid)
    else $error("wb_we high without retire_valid");

endmodule

//--- verif/tb_rv_core.sv
`include "rv_defines.svh"

module tb_rv_core;

  localparam int N_ALU = 400;
  localparam int N_UPPER = 60;
  localparam int N_MEM = 200;
  localparam int N_AFTER = 20;
  localparam int ECALL_AT = N_ALU + N_UPPER + N_MEM;
  localparam int NUM_INSNS = ECALL_AT + 1 + N_AFTER;
  // an idle gap before an instruction at most doubles the slot count
  localparam int WATCHDOG_TIME = (2 * NUM_INSNS + 20) * 10;

  logic clk;
  logic rst;
  logic insn_valid;
  rv_core_pkg::word_t insn;
  logic halt;
  logic retire_valid;
  logic wb_we;
  rv_core_pkg::word_t retire_pc;
  rv_core_pkg::word_t retire_insn;
  rv_core_pkg::word_t wb_data;
  rv_core_pkg::reg_addr_t wb_rd;

  int seed = 32'hef5fea8a;

  // reference model state
  rv_core_pkg::word_t reg_m [`RV_NUM_REGS];
  rv_core_pkg::word_t mem_m [`RV_DMEM_WORDS];
  rv_core_pkg::word_t pc_m;
  logic stopped;
  logic exp_we;
  logic exp_ecall;
  rv_core_pkg::word_t exp_data;

  // strobe sampled by the DUT at the current edge
  logic smp_valid;
  rv_core_pkg::word_t smp_insn;

  rv_core dut (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .halt         (halt),
    .retire_valid (retire_valid),
    .wb_we        (wb_we),
    .retire_pc    (retire_pc),
    .retire_insn  (retire_insn),
    .wb_data      (wb_data),
    .wb_rd        (wb_rd)
  );

  bind rv_core rv_core_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .halt         (halt),
    .retire_valid (retire_valid),
    .wb_we        (wb_we)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before the instruction stream finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // ISA behavior of one retired instruction
  task automatic execute_model(input rv_core_pkg::word_t ins, input rv_core_pkg::word_t pc);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] rd;
    logic [4:0] sh;
    logic [5:0] idx;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;
    rv_core_pkg::word_t a;
    rv_core_pkg::word_t b;
    rv_core_pkg::word_t imm_i;
    rv_core_pkg::word_t imm_s;
    rv_core_pkg::word_t addr;
    rv_core_pkg::word_t word;
    opc = ins[6:0];
    rd = ins[11:7];
    f3 = ins[14:12];
    f7 = ins[31:25];
    a = reg_m[ins[19:15]];
    b = reg_m[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    exp_we = 1'b0;
    exp_data = '0;
    exp_ecall = 1'b0;
    case (opc)
      7'b0010011, 7'b0110011: begin
        if (opc == 7'b0010011) begin
          // immediate shifts are the only forms with a funct7 field
          if (f3 == 3'b001) exp_we = (f7 == 7'h00);
          else if (f3 == 3'b101) exp_we = (f7 == 7'h00) || (f7 == 7'h20);
          else exp_we = 1'b1;
          b = imm_i;
        end else begin
          exp_we = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        end
        sh = b[4:0];
        case (f3)
          3'b000: exp_data = (opc == 7'b0110011 && f7 == 7'h20) ? a - b : a + b;
          3'b001: exp_data = a << sh;
          3'b010: exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b011: exp_data = (a < b) ? 32'd1 : 32'd0;
          3'b100: exp_data = a ^ b;
          3'b101: begin
            if (f7 == 7'h20) exp_data = $signed(a) >>> sh;
            else exp_data = a >> sh;
          end
          3'b110: exp_data = a | b;
          default: exp_data = a & b;
        endcase
      end
      7'b0110111: begin
        exp_we = 1'b1;
        exp_data = {ins[31:12], 12'b0};
      end
      7'b0010111: begin
        exp_we = 1'b1;
        exp_data = pc + {ins[31:12], 12'b0};
      end
      7'b0000011: begin
        // 256-byte wrap, word index from bits 7..2
        addr = a + imm_i;
        word = mem_m[addr[7:2]];
        sel_byte = word[{addr[1:0], 3'b000} +: 8];
        sel_half = word[{addr[1], 4'b0000} +: 16];
        exp_we = 1'b1;
        case (f3)
          3'b000: exp_data = {{24{sel_byte[7]}}, sel_byte};
          3'b001: exp_data = {{16{sel_half[15]}}, sel_half};
          3'b010: exp_data = word;
          3'b100: exp_data = {24'b0, sel_byte};
          3'b101: exp_data = {16'b0, sel_half};
          default: exp_we = 1'b0;
        endcase
      end
      7'b0100011: begin
        addr = a + imm_s;
        idx = addr[7:2];
        case (f3)
          3'b000: mem_m[idx][{addr[1:0], 3'b000} +: 8] = b[7:0];
          3'b001: mem_m[idx][{addr[1], 4'b0000} +: 16] = b[15:0];
          3'b010: mem_m[idx] = b;
          default: ;
        endcase
      end
      7'b1110011: exp_ecall = (ins[31:7] == 25'd0);
      default: ;
    endcase
    if (exp_we && rd != 5'd0) reg_m[rd] = exp_data;
  endtask

  task automatic check_retire();
    logic exp_valid;
    check_value("halt", 32'(halt), 32'(stopped));
    exp_valid = smp_valid && !stopped;
    check_value("retire_valid", 32'(retire_valid), 32'(exp_valid));
    if (exp_valid) begin
      check_value("retire_pc", retire_pc, pc_m);
      check_value("retire_insn", retire_insn, smp_insn);
      execute_model(smp_insn, pc_m);
      check_value("wb_we", 32'(wb_we), 32'(exp_we));
      if (exp_we) begin
        check_value("wb_rd", 32'(wb_rd), 32'(smp_insn[11:7]));
        check_value("wb_data", wb_data, exp_data);
      end
      pc_m = pc_m + `RV_PC_STEP;
      if (exp_ecall) stopped = 1'b1;
    end else begin
      check_value("wb_we", 32'(wb_we), 32'd0);
    end
  endtask

  // one clock: drive the next strobe, then check what the DUT just sampled
  task automatic run_slot(input logic valid, input rv_core_pkg::word_t ins);
    @(posedge clk);
    smp_valid = insn_valid;
    smp_insn = insn;
    insn_valid <= valid;
    insn <= ins;
    @(negedge clk);
    check_retire();
  endtask

  task automatic gen_alu(output rv_core_pkg::word_t ins);
    logic [31:0] r;
    logic [6:0] f7;
    r = $random(seed);
    case (r[1:0])
      2'd0: f7 = 7'h20;
      2'd3: f7 = r[31:25];
      default: f7 = 7'h00;
    endcase
    // non-shift immediates get the full 12-bit range
    if (!r[2] && r[14:12] != 3'b001 && r[14:12] != 3'b101) f7 = r[31:25];
    ins = {f7, r[24:7], r[2] ? rv_isa_pkg::OPC_REG_REG : rv_isa_pkg::OPC_REG_IMM};
  endtask

  task automatic gen_upper(output rv_core_pkg::word_t ins);
    logic [31:0] r;
    r = $random(seed);
    ins = {r[31:7], r[3] ? rv_isa_pkg::OPC_LUI : rv_isa_pkg::OPC_AUIPC};
  endtask

  task automatic gen_mem(output rv_core_pkg::word_t ins);
    logic [31:0] r;
    logic [2:0] f3;
    r = $random(seed);
    if (r[3]) begin
      f3 = (r[5:4] == 2'd3) ? 3'b010 : {1'b0, r[5:4]};
      ins = {r[31:15], f3, r[11:7], rv_isa_pkg::OPC_STORE};
    end else begin
      case (r[6:4])
        3'd0: f3 = 3'b000;
        3'd1: f3 = 3'b001;
        3'd3: f3 = 3'b100;
        3'd4: f3 = 3'b101;
        default: f3 = 3'b010;
      endcase
      ins = {r[31:15], f3, r[11:7], rv_isa_pkg::OPC_LOAD};
    end
  endtask

  initial begin
    rv_core_pkg::word_t ins;
    int idle_pick;
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    for (int i = 0; i < `RV_NUM_REGS; i++) reg_m[i] = '0;
    for (int i = 0; i < `RV_DMEM_WORDS; i++) mem_m[i] = '0;
    pc_m = `RV_RESET_PC;
    stopped = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // idle cycles, nothing may retire
    repeat (3) run_slot(1'b0, 32'd0);
    for (int i = 0; i < NUM_INSNS; i++) begin
      idle_pick = $random(seed);
      if (idle_pick % 5 == 0) run_slot(1'b0, 32'd0);
      if (i < N_ALU) gen_alu(ins);
      else if (i < N_ALU + N_UPPER) gen_upper(ins);
      else if (i < ECALL_AT) gen_mem(ins);
      else if (i == ECALL_AT) ins = 32'h0000_0073;
      else gen_alu(ins);
      run_slot(1'b1, ins);
    end
    repeat (2) run_slot(1'b0, 32'd0);
    check_value("halt", 32'(halt), 32'd1);
    $display("TEST PASSED");
    $finish;
  end

endmodule
